// ==== source/bpu_pkg.sv ====
package bpu_pkg;

    localparam int XLEN       = 32;
    localparam int HIST_WIDTH = 16;  // global history length
    localparam int TAG_WIDTH  = 10;
    localparam int PROV_WIDTH = 2;

    // which table supplied the direction
    localparam logic [PROV_WIDTH-1:0] PROV_BIMODAL = 2'd0;
    localparam logic [PROV_WIDTH-1:0] PROV_T0      = 2'd1;
    localparam logic [PROV_WIDTH-1:0] PROV_T1      = 2'd2;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    localparam logic [4:0] REG_RA = 5'd1;  // link registers
    localparam logic [4:0] REG_T0 = 5'd5;

    // one fetched word, seen through the encoding its opcode selects
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_u;

endpackage

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder (
    input  bpu_pkg::inst_u           inst_i,
    output logic                     is_branch_o,
    output logic                     is_jal_o,
    output logic                     is_jalr_o,
    output logic                     is_ret_o,
    output logic [bpu_pkg::XLEN-1:0] b_imm_o,
    output logic [bpu_pkg::XLEN-1:0] j_imm_o
);
    import bpu_pkg::*;

    logic [6:0] opcode;
    logic       rs1_is_link;
    logic       ret_shape;

    assign opcode = inst_i.raw[6:0];

    assign is_branch_o = (opcode == OP_BRANCH);
    assign is_jal_o    = (opcode == OP_JAL);
    assign is_jalr_o   = (opcode == OP_JALR);

    // return: jalr x0, 0(ra) or jalr x0, 0(t0)
    assign rs1_is_link = (inst_i.i.rs1 == REG_RA) || (inst_i.i.rs1 == REG_T0);
    assign ret_shape   = (inst_i.i.rd == 5'd0) && (inst_i.i.imm == 12'd0);
    assign is_ret_o    = is_jalr_o && rs1_is_link && ret_shape;

    // B-type offset, 13 bits with bit 0 implied
    assign b_imm_o = {
        {(XLEN-12){inst_i.b.imm12}},
        inst_i.b.imm11,
        inst_i.b.imm10_5,
        inst_i.b.imm4_1,
        1'b0
    };

    // J-type offset, 21 bits with bit 0 implied
    assign j_imm_o = {
        {(XLEN-20){inst_i.j.imm20}},
        inst_i.j.imm19_12,
        inst_i.j.imm11,
        inst_i.j.imm10_1,
        1'b0
    };

endmodule

// ==== source/tage_predictor.sv ====
`timescale 1ns/1ns

module tage_predictor #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGE_ENTRIES    = 256
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [bpu_pkg::XLEN-1:0]       pc_i,
    output logic                           taken_o,
    output logic [bpu_pkg::PROV_WIDTH-1:0] provider_o,
    output logic [bpu_pkg::HIST_WIDTH-1:0] history_o,
    input  logic                           upd_valid_i,
    input  logic                           upd_taken_i,
    input  logic                           upd_correct_i,
    input  logic [bpu_pkg::XLEN-1:0]       upd_pc_i,
    input  logic [bpu_pkg::HIST_WIDTH-1:0] upd_history_i,
    input  logic [bpu_pkg::PROV_WIDTH-1:0] upd_provider_i
);
    import bpu_pkg::*;

    localparam int BM_W = $clog2(BIMODAL_ENTRIES);
    localparam int TG_W = $clog2(TAGE_ENTRIES);

    logic [1:0]            bm_ctr [BIMODAL_ENTRIES];
    logic [1:0]            t0_ctr [TAGE_ENTRIES];
    logic [1:0]            t1_ctr [TAGE_ENTRIES];
    logic [TAG_WIDTH-1:0]  t0_tag [TAGE_ENTRIES];
    logic [TAG_WIDTH-1:0]  t1_tag [TAGE_ENTRIES];
    logic                  t0_vld [TAGE_ENTRIES];
    logic                  t1_vld [TAGE_ENTRIES];
    logic [HIST_WIDTH-1:0] ghist;

    function automatic logic [TG_W-1:0] t0_index(input logic [XLEN-1:0] pc,
                                                 input logic [HIST_WIDTH-1:0] hist);
        return pc[TG_W+1:2] ^ TG_W'(hist);  // newest history bits
    endfunction

    function automatic logic [TG_W-1:0] t1_index(input logic [XLEN-1:0] pc,
                                                 input logic [HIST_WIDTH-1:0] hist);
        return pc[TG_W+1:2] ^ TG_W'(hist >> TG_W);  // next older window
    endfunction

    function automatic logic [TAG_WIDTH-1:0] t0_tag_of(input logic [XLEN-1:0] pc,
                                                       input logic [HIST_WIDTH-1:0] hist);
        return pc[TG_W+2 +: TAG_WIDTH] ^ hist[HIST_WIDTH-1 -: TAG_WIDTH];
    endfunction

    function automatic logic [TAG_WIDTH-1:0] t1_tag_of(input logic [XLEN-1:0] pc,
                                                       input logic [HIST_WIDTH-1:0] hist);
        return pc[TG_W+2 +: TAG_WIDTH] ^ {{(TAG_WIDTH-8){1'b0}}, hist[7:0]};
    endfunction

    function automatic logic [1:0] sat_step(input logic [1:0] ctr, input logic up);
        if (up) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

    // lookup side, indexed with the live history
    logic [BM_W-1:0]      lk_bm_idx;
    logic [TG_W-1:0]      lk_t0_idx, lk_t1_idx;
    logic                 t0_hit, t1_hit;

    assign lk_bm_idx = pc_i[BM_W:1];
    assign lk_t0_idx = t0_index(pc_i, ghist);
    assign lk_t1_idx = t1_index(pc_i, ghist);
    assign t0_hit    = t0_vld[lk_t0_idx] && (t0_tag[lk_t0_idx] == t0_tag_of(pc_i, ghist));
    assign t1_hit    = t1_vld[lk_t1_idx] && (t1_tag[lk_t1_idx] == t1_tag_of(pc_i, ghist));

    always_comb begin
        if (t1_hit) begin  // longest history wins
            taken_o    = t1_ctr[lk_t1_idx][1];
            provider_o = PROV_T1;
        end else if (t0_hit) begin
            taken_o    = t0_ctr[lk_t0_idx][1];
            provider_o = PROV_T0;
        end else begin
            taken_o    = bm_ctr[lk_bm_idx][1];
            provider_o = PROV_BIMODAL;
        end
    end

    assign history_o = ghist;

    // update side, indexed with the history the prediction was made under
    logic [BM_W-1:0]      up_bm_idx;
    logic [TG_W-1:0]      up_t0_idx, up_t1_idx;
    logic [TAG_WIDTH-1:0] up_t0_tag, up_t1_tag;
    logic                 up_t1_match;
    logic                 alloc, alloc_t0, alloc_t1;
    logic [1:0]           alloc_ctr;

    assign up_bm_idx   = upd_pc_i[BM_W:1];
    assign up_t0_idx   = t0_index(upd_pc_i, upd_history_i);
    assign up_t1_idx   = t1_index(upd_pc_i, upd_history_i);
    assign up_t0_tag   = t0_tag_of(upd_pc_i, upd_history_i);
    assign up_t1_tag   = t1_tag_of(upd_pc_i, upd_history_i);
    assign up_t1_match = t1_vld[up_t1_idx] && (t1_tag[up_t1_idx] == up_t1_tag);

    // bimodal miss allocates, T1 first
    assign alloc     = upd_valid_i && !upd_correct_i && (upd_provider_i == PROV_BIMODAL);
    assign alloc_t1  = alloc && !up_t1_match;
    assign alloc_t0  = alloc && up_t1_match;
    assign alloc_ctr = upd_taken_i ? 2'b10 : 2'b01;  // weak toward outcome

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int k = 0; k < BIMODAL_ENTRIES; k++) begin
                bm_ctr[k] <= 2'b01;
            end
            for (int k = 0; k < TAGE_ENTRIES; k++) begin
                t0_ctr[k] <= 2'b01;
                t1_ctr[k] <= 2'b01;
                t0_vld[k] <= 1'b0;
                t1_vld[k] <= 1'b0;
            end
        end else if (upd_valid_i) begin
            ghist             <= {ghist[HIST_WIDTH-2:0], upd_taken_i};
            bm_ctr[up_bm_idx] <= sat_step(bm_ctr[up_bm_idx], upd_taken_i);
            if (upd_provider_i == PROV_T0) begin
                t0_ctr[up_t0_idx] <= upd_correct_i ? sat_step(t0_ctr[up_t0_idx], upd_taken_i)
                                                   : {2{upd_taken_i}};  // strong flip
            end
            if (upd_provider_i == PROV_T1) begin
                t1_ctr[up_t1_idx] <= upd_correct_i ? sat_step(t1_ctr[up_t1_idx], upd_taken_i)
                                                   : {2{upd_taken_i}};
            end
            if (alloc_t1) begin
                t1_ctr[up_t1_idx] <= alloc_ctr;
                t1_vld[up_t1_idx] <= 1'b1;
            end
            if (alloc_t0) begin
                t0_ctr[up_t0_idx] <= alloc_ctr;
                t0_vld[up_t0_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_t1) begin
            t1_tag[up_t1_idx] <= up_t1_tag;
        end
        if (alloc_t0) begin
            t0_tag[up_t0_idx] <= up_t0_tag;
        end
    end

endmodule

// ==== source/branch_target_buffer.sv ====
`timescale 1ns/1ns

module branch_target_buffer #(
    parameter int BTB_ENTRIES = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] pc_i,
    output logic                     hit_o,
    output logic [bpu_pkg::XLEN-1:0] target_o,
    input  logic                     upd_valid_i,
    input  logic                     upd_taken_i,
    input  logic [bpu_pkg::XLEN-1:0] upd_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] upd_target_i
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = XLEN - IDX_W - 2;  // everything above the index

    logic [TAG_W-1:0] tag_mem    [BTB_ENTRIES];
    logic [XLEN-1:0]  target_mem [BTB_ENTRIES];
    logic             valid_mem  [BTB_ENTRIES];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] up_idx;
    logic [TAG_W-1:0] up_tag;
    logic             write_en;

    // word-aligned pc, low two bits dropped
    assign lk_idx = pc_i[IDX_W+1:2];
    assign lk_tag = pc_i[XLEN-1:IDX_W+2];
    assign up_idx = upd_pc_i[IDX_W+1:2];
    assign up_tag = upd_pc_i[XLEN-1:IDX_W+2];

    assign hit_o    = valid_mem[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    assign target_o = target_mem[lk_idx];

    assign write_en = upd_valid_i && upd_taken_i;  // only taken transfers fill

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < BTB_ENTRIES; k++) begin
                valid_mem[k] <= 1'b0;
            end
        end else if (write_en) begin
            valid_mem[up_idx] <= 1'b1;
        end
    end

    // tag and target, overwritten in place
    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_mem[up_idx]    <= up_tag;
            target_mem[up_idx] <= upd_target_i;
        end
    end

endmodule

// ==== source/return_stack.sv ====
`timescale 1ns/1ns

module return_stack #(
    parameter int RAS_DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push_i,
    input  logic [bpu_pkg::XLEN-1:0] push_addr_i,
    input  logic                     pop_i,
    output logic [bpu_pkg::XLEN-1:0] top_o,
    output logic                     nonempty_o
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(RAS_DEPTH);
    localparam int PTR_W = IDX_W + 1;  // counts 0..RAS_DEPTH

    logic [XLEN-1:0]  stack [RAS_DEPTH];
    logic [PTR_W-1:0] sp;  // number of live entries
    logic [PTR_W-1:0] sp_dec;
    logic [PTR_W-1:0] sp_after_pop;
    logic             do_pop;
    logic             do_push;

    assign sp_dec     = sp - 1'b1;
    assign nonempty_o = (sp != '0);
    assign top_o      = stack[sp_dec[IDX_W-1:0]];

    // pop first, then push into the freed slot
    assign do_pop       = pop_i && nonempty_o;
    assign sp_after_pop = do_pop ? sp_dec : sp;
    assign do_push      = push_i && (sp_after_pop != PTR_W'(RAS_DEPTH));  // full drops

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= '0;
        end else if (do_push) begin
            sp <= sp_after_pop + 1'b1;
        end else begin
            sp <= sp_after_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack[sp_after_pop[IDX_W-1:0]] <= push_addr_i;
        end
    end

endmodule

// ==== source/target_select.sv ====
`timescale 1ns/1ns

module target_select (
    input  logic [bpu_pkg::XLEN-1:0] pc_i,
    input  logic                     is_branch_i,
    input  logic                     is_jal_i,
    input  logic                     is_jalr_i,
    input  logic                     is_ret_i,
    input  logic                     dir_taken_i,
    input  logic                     btb_hit_i,
    input  logic                     ras_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] b_imm_i,
    input  logic [bpu_pkg::XLEN-1:0] j_imm_i,
    input  logic [bpu_pkg::XLEN-1:0] btb_target_i,
    input  logic [bpu_pkg::XLEN-1:0] ras_top_i,
    output logic                     is_ctrl_o,
    output logic                     taken_o,
    output logic [bpu_pkg::XLEN-1:0] pred_pc_o
);
    import bpu_pkg::*;

    logic [XLEN-1:0] seq_pc;

    assign seq_pc    = pc_i + XLEN'(4);
    assign is_ctrl_o = is_branch_i || is_jal_i || is_jalr_i;

    always_comb begin
        taken_o   = 1'b0;  // fall through unless decided otherwise
        pred_pc_o = seq_pc;
        if (is_ret_i) begin
            if (ras_valid_i) begin  // empty stack falls through
                taken_o   = 1'b1;
                pred_pc_o = ras_top_i;
            end
        end else if (is_jal_i) begin
            taken_o   = 1'b1;
            pred_pc_o = btb_hit_i ? btb_target_i : pc_i + j_imm_i;
        end else if (is_branch_i || is_jalr_i) begin
            taken_o = dir_taken_i;
            if (dir_taken_i) begin
                if (btb_hit_i) begin
                    pred_pc_o = btb_target_i;
                end else if (is_branch_i) begin
                    pred_pc_o = pc_i + b_imm_i;
                end
                // indirect jump without btb entry stays at pc+4
            end
        end
    end

endmodule

// ==== source/bpu_top.sv ====
`timescale 1ns/1ns

module bpu_top #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGE_ENTRIES    = 256,
    parameter int BTB_ENTRIES     = 256,
    parameter int RAS_DEPTH       = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [bpu_pkg::XLEN-1:0]       if_pc_i,
    input  bpu_pkg::inst_u                 if_inst_i,
    output logic                           is_ctrl_o,
    output logic                           pred_taken_o,
    output logic [bpu_pkg::XLEN-1:0]       pred_pc_o,
    output logic [bpu_pkg::PROV_WIDTH-1:0] provider_o,
    output logic [bpu_pkg::HIST_WIDTH-1:0] history_o,
    input  logic                           ex_valid_i,
    input  logic                           ex_taken_i,
    input  logic                           ex_correct_i,
    input  logic [bpu_pkg::XLEN-1:0]       ex_pc_i,
    input  bpu_pkg::inst_u                 ex_inst_i,
    input  logic [bpu_pkg::XLEN-1:0]       ex_target_i,
    input  logic [bpu_pkg::HIST_WIDTH-1:0] ex_history_i,
    input  logic [bpu_pkg::PROV_WIDTH-1:0] ex_provider_i,
    input  logic                           id_push_i,
    input  logic [bpu_pkg::XLEN-1:0]       id_push_addr_i,
    input  logic                           stall_i
);
    import bpu_pkg::*;

    logic            if_is_branch, if_is_jal, if_is_jalr, if_is_ret;
    logic [XLEN-1:0] if_b_imm, if_j_imm;
    logic            ex_is_ret;
    logic            dir_taken;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic [XLEN-1:0] ras_top;
    logic            ras_nonempty;
    logic            ras_push, ras_pop;

    // fetch word
    inst_decoder u_if_dec (
        .inst_i(if_inst_i), .is_branch_o(if_is_branch), .is_jal_o(if_is_jal),
        .is_jalr_o(if_is_jalr), .is_ret_o(if_is_ret), .b_imm_o(if_b_imm), .j_imm_o(if_j_imm)
    );

    // resolved word, only the return flag matters here
    inst_decoder u_ex_dec (
        .inst_i(ex_inst_i), .is_branch_o(), .is_jal_o(), .is_jalr_o(),
        .is_ret_o(ex_is_ret), .b_imm_o(), .j_imm_o()
    );

    tage_predictor #(.BIMODAL_ENTRIES(BIMODAL_ENTRIES), .TAGE_ENTRIES(TAGE_ENTRIES)) u_tage (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .taken_o(dir_taken), .provider_o(provider_o),
        .history_o(history_o), .upd_valid_i(ex_valid_i), .upd_taken_i(ex_taken_i),
        .upd_correct_i(ex_correct_i), .upd_pc_i(ex_pc_i), .upd_history_i(ex_history_i),
        .upd_provider_i(ex_provider_i)
    );

    branch_target_buffer #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .hit_o(btb_hit), .target_o(btb_target),
        .upd_valid_i(ex_valid_i), .upd_taken_i(ex_taken_i), .upd_pc_i(ex_pc_i),
        .upd_target_i(ex_target_i)
    );

    assign ras_pop  = ex_valid_i && ex_taken_i && ex_is_ret && !stall_i;
    assign ras_push = id_push_i && !stall_i;  // stall freezes the stack

    return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .clk(clk), .rst(rst), .push_i(ras_push), .push_addr_i(id_push_addr_i),
        .pop_i(ras_pop), .top_o(ras_top), .nonempty_o(ras_nonempty)
    );

    target_select u_sel (
        .pc_i(if_pc_i), .is_branch_i(if_is_branch), .is_jal_i(if_is_jal),
        .is_jalr_i(if_is_jalr), .is_ret_i(if_is_ret), .dir_taken_i(dir_taken),
        .btb_hit_i(btb_hit), .ras_valid_i(ras_nonempty), .b_imm_i(if_b_imm),
        .j_imm_i(if_j_imm), .btb_target_i(btb_target), .ras_top_i(ras_top),
        .is_ctrl_o(is_ctrl_o), .taken_o(pred_taken_o), .pred_pc_o(pred_pc_o)
    );

endmodule

// ==== tb/bpu_properties.sv ====
`timescale 1ns/1ns

module bpu_properties (
    input logic                           clk,
    input logic                           rst,
    input logic                           is_ctrl_o,
    input logic                           pred_taken_o,
    input logic [bpu_pkg::PROV_WIDTH-1:0] provider_o,
    input logic [bpu_pkg::HIST_WIDTH-1:0] history_o
);
    import bpu_pkg::*;

    // only branches and jumps can redirect fetch
    taken_needs_ctrl: assert property (@(posedge clk) disable iff (rst)
        pred_taken_o |-> is_ctrl_o)
        else $error("pred_taken_o high for a word that is not a branch or jump");

    provider_known: assert property (@(posedge clk) disable iff (rst)
        (provider_o == PROV_BIMODAL) || (provider_o == PROV_T0) || (provider_o == PROV_T1))
        else $error("provider_o holds the unused code");

    // history starts clean once reset lets go
    history_clear_after_reset: assert property (@(posedge clk)
        rst |=> (history_o == '0))
        else $error("history_o not zero in the cycle after reset");

endmodule

bind bpu_top bpu_properties u_props (
    .clk(clk), .rst(rst), .is_ctrl_o(is_ctrl_o), .pred_taken_o(pred_taken_o),
    .provider_o(provider_o), .history_o(history_o)
);

// ==== tb/bpu_tb.sv ====
`timescale 1ns/1ns

module bpu_tb;
    import bpu_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int TEST_CYCLES = 40;  // all directed tests, with some slack
    localparam logic [XLEN-1:0] J_OFF = 32'hffff_f9f8;  // -1544
    localparam logic [XLEN-1:0] NOP   = 32'h0000_0013;  // addi x0, x0, 0

    logic                  clk, rst;
    logic [XLEN-1:0]       if_pc_i;
    inst_u                 if_inst_i;
    logic                  is_ctrl_o, pred_taken_o;
    logic [XLEN-1:0]       pred_pc_o;
    logic [PROV_WIDTH-1:0] provider_o;
    logic [HIST_WIDTH-1:0] history_o;
    logic                  ex_valid_i, ex_taken_i, ex_correct_i;
    logic [XLEN-1:0]       ex_pc_i, ex_target_i;
    inst_u                 ex_inst_i;
    logic [HIST_WIDTH-1:0] ex_history_i;
    logic [PROV_WIDTH-1:0] ex_provider_i;
    logic                  id_push_i, stall_i;
    logic [XLEN-1:0]       id_push_addr_i;

    integer                seed = 32'h39fc_b888;
    logic [HIST_WIDTH-1:0] exp_hist;  // shift model of the global history
    logic [XLEN-1:0]       p_jal, p_br, p_ret;

    bpu_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_prov(input string name, input logic [PROV_WIDTH-1:0] got,
                              input logic [PROV_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_hist(input string name, input logic [HIST_WIDTH-1:0] got,
                              input logic [HIST_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic inst_u jal_word(input logic [XLEN-1:0] off);
        inst_u w;
        w            = '0;
        w.j.opcode   = OP_JAL;
        w.j.rd       = REG_RA;  // a call
        w.j.imm20    = off[20];
        w.j.imm19_12 = off[19:12];
        w.j.imm11    = off[11];
        w.j.imm10_1  = off[10:1];
        return w;
    endfunction

    function automatic inst_u branch_word();
        inst_u w;
        w           = '0;
        w.b.opcode  = OP_BRANCH;
        w.b.rs1     = 5'd1;
        w.b.rs2     = 5'd2;
        w.b.imm10_5 = 6'd2;  // +64
        return w;
    endfunction

    function automatic inst_u ret_word();
        inst_u w;
        w          = '0;
        w.i.opcode = OP_JALR;
        w.i.rs1    = REG_RA;
        return w;
    endfunction

    // word aligned, and btb / bimodal index bits differ between the three
    task automatic pick_pcs();
        p_jal = $random(seed) & 32'hffff_fffc;
        p_br  = p_jal;
        while (p_br[9:2] == p_jal[9:2]) begin
            p_br = $random(seed) & 32'hffff_fffc;
        end
        p_ret = p_jal;
        while (p_ret[9:2] == p_jal[9:2] || p_ret[9:2] == p_br[9:2]) begin
            p_ret = $random(seed) & 32'hffff_fffc;
        end
    endtask

    task automatic fetch(input logic [XLEN-1:0] pc, input inst_u inst);
        @(negedge clk);
        if_pc_i   = pc;
        if_inst_i = inst;
        @(posedge clk);  // no write at this edge, outputs are settled
    endtask

    // one EX strobe, always reported with the bimodal provider
    task automatic resolve(input logic [XLEN-1:0] pc, input inst_u inst, input logic taken,
                           input logic correct, input logic [XLEN-1:0] target,
                           input logic [HIST_WIDTH-1:0] hist, input logic stall);
        @(negedge clk);
        ex_valid_i    = 1'b1;
        ex_pc_i       = pc;
        ex_inst_i     = inst;
        ex_taken_i    = taken;
        ex_correct_i  = correct;
        ex_target_i   = target;
        ex_history_i  = hist;
        ex_provider_i = PROV_BIMODAL;
        stall_i       = stall;
        @(negedge clk);
        ex_valid_i = 1'b0;
        stall_i    = 1'b0;
        exp_hist   = {exp_hist[HIST_WIDTH-2:0], taken};
        check_hist("history_o", history_o, exp_hist);
    endtask

    task automatic push(input logic [XLEN-1:0] addr);
        @(negedge clk);
        id_push_i      = 1'b1;
        id_push_addr_i = addr;
        @(negedge clk);
        id_push_i = 1'b0;
    endtask

    task automatic test_reset_state();
        fetch(p_br, branch_word());
        check_bit("is_ctrl_o", is_ctrl_o, 1'b1);
        check_bit("pred_taken_o", pred_taken_o, 1'b0);
        check_addr("pred_pc_o", pred_pc_o, p_br + 32'd4);
        check_prov("provider_o", provider_o, PROV_BIMODAL);
        check_hist("history_o", history_o, '0);
        fetch(p_br, NOP);
        check_bit("is_ctrl_o", is_ctrl_o, 1'b0);
        check_bit("pred_taken_o", pred_taken_o, 1'b0);
    endtask

    task automatic test_jal_btb();
        fetch(p_jal, jal_word(J_OFF));
        check_bit("pred_taken_o", pred_taken_o, 1'b1);
        check_addr("pred_pc_o", pred_pc_o, p_jal + J_OFF);
        resolve(p_jal, jal_word(J_OFF), 1'b1, 1'b1, p_jal + 32'h4000, exp_hist, 1'b0);
        fetch(p_jal, jal_word(J_OFF));
        check_bit("pred_taken_o", pred_taken_o, 1'b1);
        check_addr("pred_pc_o", pred_pc_o, p_jal + 32'h4000);
    endtask

    task automatic test_bimodal_train();
        repeat (2) resolve(p_br, branch_word(), 1'b1, 1'b1, p_br + 32'h200, exp_hist, 1'b0);
        fetch(p_br, branch_word());
        check_bit("pred_taken_o", pred_taken_o, 1'b1);
        check_addr("pred_pc_o", pred_pc_o, p_br + 32'h200);
        check_prov("provider_o", provider_o, PROV_BIMODAL);
    endtask

    // mispredict on a strong bimodal counter, history as it reads after the shift
    task automatic test_tagged_alloc();
        resolve(p_br, branch_word(), 1'b0, 1'b0, p_br + 32'd4,
                {exp_hist[HIST_WIDTH-2:0], 1'b0}, 1'b0);
        fetch(p_br, branch_word());
        check_prov("provider_o", provider_o, PROV_T1);
        check_bit("pred_taken_o", pred_taken_o, 1'b0);
        check_addr("pred_pc_o", pred_pc_o, p_br + 32'd4);
    endtask

    task automatic test_return_stack();
        logic [XLEN-1:0] addr_a, addr_b;
        addr_a = $random(seed) & 32'hffff_fffc;
        addr_b = addr_a ^ 32'h0001_0000;
        push(addr_a);
        push(addr_b);
        fetch(p_ret, ret_word());
        check_bit("is_ctrl_o", is_ctrl_o, 1'b1);
        check_bit("pred_taken_o", pred_taken_o, 1'b1);
        check_addr("pred_pc_o", pred_pc_o, addr_b);
        resolve(p_ret, ret_word(), 1'b1, 1'b1, addr_b, exp_hist, 1'b0);
        fetch(p_ret, ret_word());
        check_addr("pred_pc_o", pred_pc_o, addr_a);
        resolve(p_ret, ret_word(), 1'b1, 1'b1, addr_a, exp_hist, 1'b1);  // stalled pop
        fetch(p_ret, ret_word());
        check_bit("pred_taken_o", pred_taken_o, 1'b1);
        check_addr("pred_pc_o", pred_pc_o, addr_a);
        resolve(p_ret, ret_word(), 1'b1, 1'b1, addr_a, exp_hist, 1'b0);
        fetch(p_ret, ret_word());
        check_bit("pred_taken_o", pred_taken_o, 1'b0);
        check_addr("pred_pc_o", pred_pc_o, p_ret + 32'd4);
    endtask

    initial begin
        #((TEST_CYCLES + 50) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        if_pc_i        = '0;
        if_inst_i      = '0;
        ex_valid_i     = 1'b0;
        ex_taken_i     = 1'b0;
        ex_correct_i   = 1'b0;
        ex_pc_i        = '0;
        ex_inst_i      = '0;
        ex_target_i    = '0;
        ex_history_i   = '0;
        ex_provider_i  = PROV_BIMODAL;
        id_push_i      = 1'b0;
        id_push_addr_i = '0;
        stall_i        = 1'b0;
        exp_hist       = '0;
        pick_pcs();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_jal_btb();
        test_bimodal_train();
        test_tagged_alloc();
        test_return_stack();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
source/bpu_pkg.sv
source/inst_decoder.sv
source/tage_predictor.sv
source/branch_target_buffer.sv
source/return_stack.sv
source/target_select.sv
source/bpu_top.sv
tb/bpu_properties.sv
tb/bpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module bpu_tb \
        -f all.f -o bpu_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/bpu_sim 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
